// ==== psram_settings.svh ====
`ifndef PSRAM_SETTINGS_SVH
`define PSRAM_SETTINGS_SVH

// Address bits actually stored by the device model
// The full 24-bit address wraps into this space
`define PSRAM_MEM_BITS 12

// Width of the burst byte count
`define PSRAM_LEN_BITS 8

// Device cycle marks, counted from the first cycle with chip-select low
`define PSRAM_CMD_END 8
`define PSRAM_ADDR_END 14

// First device cycle on which the device drives read data
`define PSRAM_READ_START 20

`endif

// ==== psram_pkg.sv ====
`default_nettype none
`include "psram_settings.svh"

package psram_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [3:0] nibble_t;
    typedef logic [`PSRAM_LEN_BITS-1:0] len_t;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h38,
        CMD_READ  = 8'hEB
    } psram_cmd_t;

    typedef enum logic [2:0] {
        PS_CMD,
        PS_ADDR,
        PS_WAIT,
        PS_WDATA,
        PS_RDATA,
        PS_ERR
    } psram_state_t;

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_CMD,
        SQ_ADDR,
        SQ_WDATA,
        SQ_RWAIT,
        SQ_RDATA,
        SQ_DONE
    } seq_state_t;

    // Which way the host lanes face in the current device cycle
    typedef enum logic [2:0] {
        PH_CMD,
        PH_ADDR,
        PH_WRITE,
        PH_TURN,
        PH_READ
    } lane_phase_t;

endpackage

`default_nettype wire

// ==== psram_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "psram_settings.svh"

module psram_model (
    input wire                 sck,
    input wire                 ce_n,
    inout wire psram_pkg::nibble_t dio
);
    import psram_pkg::*;

    localparam int unsigned MEM_BYTES = 2 ** `PSRAM_MEM_BITS;
    localparam logic [5:0] CMD_LAST = 6'(`PSRAM_CMD_END - 1);
    localparam logic [5:0] ADDR_LAST = 6'(`PSRAM_ADDR_END - 1);
    localparam logic [5:0] WAIT_LAST = 6'(`PSRAM_READ_START - 1);

    byte_t mem [MEM_BYTES];

    psram_state_t state;
    psram_state_t next_state;
    logic [5:0] count;
    byte_t cmd;
    addr_t addr;
    nibble_t wr_hi;
    logic drive;
    logic [`PSRAM_MEM_BITS-1:0] idx;
    byte_t rd_byte;

    // Only the low address bits select a byte, so the 24-bit address wraps
    assign idx = addr[`PSRAM_MEM_BITS-1:0];
    assign rd_byte = mem[idx];

    // Read data goes out low nibble on even cycles, high nibble on odd cycles
    assign dio = drive ? (count[0] ? rd_byte[7:4] : rd_byte[3:0]) : 'z;

    always_comb begin
        next_state = state;
        case (state)
            PS_CMD: begin
                if (count == CMD_LAST) begin
                    next_state = PS_ADDR;
                end
            end
            PS_ADDR: begin
                if (count == ADDR_LAST) begin
                    if (cmd == CMD_WRITE) begin
                        next_state = PS_WDATA;
                    end else if (cmd == CMD_READ) begin
                        next_state = PS_WAIT;
                    end else begin
                        next_state = PS_ERR;
                    end
                end
            end
            PS_WAIT: begin
                if (count == WAIT_LAST) begin
                    next_state = PS_RDATA;
                end
            end
            default: begin
                next_state = state;
            end
        endcase
    end

    // Chip-select high holds the whole device in reset
    always_ff @(posedge sck or posedge ce_n) begin
        if (ce_n) begin
            state <= PS_CMD;
            count <= '0;
            cmd <= '0;
            addr <= '0;
            drive <= 1'b0;
        end else begin
            state <= next_state;
            count <= count + 6'd1;
            if (state == PS_CMD) begin
                cmd <= {cmd[6:0], dio[0]};
            end
            if (cmd == CMD_READ && count == WAIT_LAST) begin
                drive <= 1'b1;
            end
            if (state == PS_ADDR) begin
                addr <= {addr[19:0], dio};
            end else if ((state == PS_WDATA || state == PS_RDATA) && count[0]) begin
                addr <= addr + 24'd1;
            end
        end
    end

    // Write bytes arrive high nibble first and land on the odd cycle
    always_ff @(posedge sck) begin
        if (state == PS_WDATA) begin
            if (count[0]) begin
                mem[idx] <= {wr_hi, dio};
            end else begin
                wr_hi <= dio;
            end
        end
    end

    a_no_error: assert property (@(posedge sck) disable iff (ce_n)
        state != PS_ERR);

    // The output enable is timed by the cycle count and must agree with the FSM
    a_drive_rdata: assert property (@(posedge sck) disable iff (ce_n)
        drive |-> state == PS_RDATA);

endmodule

`default_nettype wire

// ==== qspi_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "psram_settings.svh"

module qspi_sequencer (
    input  wire                    sck,
    input  wire                    reset,
    input  wire                    start,
    input  wire                    write,
    input  wire psram_pkg::len_t   len,
    output logic                   busy,
    output logic                   done,
    output logic                   ce_n,
    output psram_pkg::lane_phase_t phase,
    output logic                   load,
    output logic                   step,
    output logic                   sample,
    output logic                   byte_last,
    output logic                   wr_take
);
    import psram_pkg::*;

    localparam logic [5:0] CMD_LAST = 6'(`PSRAM_CMD_END - 1);
    localparam logic [5:0] ADDR_LAST = 6'(`PSRAM_ADDR_END - 1);
    localparam logic [5:0] WAIT_LAST = 6'(`PSRAM_READ_START - 1);

    seq_state_t state;
    seq_state_t next_state;
    logic [5:0] cyc;
    len_t left;
    logic wr_q;
    logic in_data;
    logic byte_end;

    always_comb begin
        next_state = state;
        case (state)
            SQ_IDLE: if (start) next_state = SQ_CMD;
            SQ_CMD: if (cyc == CMD_LAST) next_state = SQ_ADDR;
            SQ_ADDR: if (cyc == ADDR_LAST) next_state = wr_q ? SQ_WDATA : SQ_RWAIT;
            SQ_RWAIT: if (cyc == WAIT_LAST) next_state = SQ_RDATA;
            SQ_WDATA, SQ_RDATA: if (byte_last && byte_end) next_state = SQ_DONE;
            SQ_DONE: next_state = SQ_IDLE;
            default: next_state = SQ_IDLE;
        endcase
    end

    // cyc mirrors the device cycle counter inside the model
    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            state <= SQ_IDLE;
            ce_n <= 1'b1;
            cyc <= '0;
            left <= '0;
            wr_q <= 1'b0;
        end else begin
            state <= next_state;
            ce_n <= (next_state == SQ_IDLE) || (next_state == SQ_DONE);
            if (load) begin
                cyc <= '0;
                left <= len;
                wr_q <= write;
            end else if (busy) begin
                cyc <= cyc + 6'd1;
                if (byte_end) begin
                    left <= left - len_t'(1);
                end
            end
        end
    end

    assign busy = state != SQ_IDLE;
    assign done = state == SQ_DONE;
    assign load = (state == SQ_IDLE) && start;
    assign step = (state == SQ_CMD) || (state == SQ_ADDR) || (state == SQ_WDATA);

    // Each data byte spans an even and an odd device cycle
    assign in_data = (state == SQ_WDATA) || (state == SQ_RDATA);
    assign byte_end = in_data && cyc[0];
    assign byte_last = in_data && (left == len_t'(1));
    assign wr_take = (state == SQ_WDATA) && !cyc[0];

    // The next write byte is fetched one cycle before it goes out
    assign sample = ((state == SQ_ADDR) && (cyc == ADDR_LAST) && wr_q)
                  || ((state == SQ_WDATA) && byte_end && !byte_last)
                  || ((state == SQ_RDATA) && byte_end);

    always_comb begin
        case (state)
            SQ_CMD: phase = PH_CMD;
            SQ_ADDR: phase = PH_ADDR;
            SQ_WDATA: phase = PH_WRITE;
            SQ_RDATA: phase = PH_READ;
            default: phase = PH_TURN;
        endcase
    end

    a_start_idle: assert property (@(posedge sck) disable iff (reset)
        start |-> !busy);

    a_len_nonzero: assert property (@(posedge sck) disable iff (reset)
        start |-> len != '0);

endmodule

`default_nettype wire

// ==== qspi_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module qspi_datapath (
    input  wire                    sck,
    input  wire                    reset,
    input  wire psram_pkg::lane_phase_t phase,
    input  wire                    load,
    input  wire                    step,
    input  wire                    sample,
    input  wire                    write,
    input  wire psram_pkg::addr_t  addr,
    input  wire psram_pkg::byte_t  wr_data,
    inout  wire psram_pkg::nibble_t dio,
    output psram_pkg::byte_t       rd_data,
    output logic                   rd_valid
);
    import psram_pkg::*;

    psram_cmd_t cmd;
    logic [31:0] shifter;
    logic oe;
    nibble_t dout;
    nibble_t rd_lo;

    assign cmd = write ? CMD_WRITE : CMD_READ;

    // The host owns the bus until the data direction turns around
    assign oe = (phase == PH_CMD) || (phase == PH_ADDR) || (phase == PH_WRITE);

    // Command bits only use lane 0
    assign dout = (phase == PH_CMD) ? {3'b000, shifter[31]} : shifter[31:28];
    assign dio = oe ? dout : 'z;

    // Top of the shifter is always what goes out in the current cycle
    always_ff @(posedge sck) begin
        if (load) begin
            shifter <= {cmd, addr};
        end else if (sample && phase != PH_READ) begin
            shifter[31:24] <= wr_data;
        end else if (step) begin
            if (phase == PH_CMD) begin
                shifter <= {shifter[30:0], 1'b0};
            end else begin
                shifter <= {shifter[27:0], 4'h0};
            end
        end
    end

    // Read data comes low nibble first
    always_ff @(posedge sck) begin
        if (phase == PH_READ) begin
            if (sample) begin
                rd_data <= {dio, rd_lo};
            end else begin
                rd_lo <= dio;
            end
        end
    end

    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= sample && (phase == PH_READ);
        end
    end

endmodule

`default_nettype wire

// ==== psram_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module psram_subsystem (
    input  wire                   sck,
    input  wire                   reset,
    input  wire                   start,
    input  wire                   write,
    input  wire psram_pkg::addr_t addr,
    input  wire psram_pkg::len_t  len,
    input  wire psram_pkg::byte_t wr_data,
    output wire                   busy,
    output wire                   done,
    output wire                   wr_take,
    output wire psram_pkg::byte_t rd_data,
    output wire                   rd_valid
);
    import psram_pkg::*;

    wire ce_n;
    wire lane_phase_t phase;
    wire load;
    wire step;
    wire sample;
    wire nibble_t dio;

    qspi_sequencer seq0 (
        .sck       (sck),
        .reset     (reset),
        .start     (start),
        .write     (write),
        .len       (len),
        .busy      (busy),
        .done      (done),
        .ce_n      (ce_n),
        .phase     (phase),
        .load      (load),
        .step      (step),
        .sample    (sample),
        .byte_last (),
        .wr_take   (wr_take)
    );

    qspi_datapath dp0 (
        .sck      (sck),
        .reset    (reset),
        .phase    (phase),
        .load     (load),
        .step     (step),
        .sample   (sample),
        .write    (write),
        .addr     (addr),
        .wr_data  (wr_data),
        .dio      (dio),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    psram_model mem0 (
        .sck  (sck),
        .ce_n (ce_n),
        .dio  (dio)
    );

endmodule

`default_nettype wire

// ==== tb_psram_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "psram_settings.svh"

module tb_psram_subsystem;
    import psram_pkg::*;

    localparam int MEM_BITS = `PSRAM_MEM_BITS;
    localparam int MEM_BYTES = 2 ** MEM_BITS;
    localparam time DLY = 2ns;
    localparam int TIMEOUT = 200;

    typedef logic [MEM_BITS-1:0] mem_idx_t;

    logic sck;
    logic reset;
    logic start;
    logic write;
    addr_t addr;
    len_t len;
    byte_t wr_data;
    wire busy;
    wire done;
    wire wr_take;
    byte_t rd_data;
    wire rd_valid;

    byte_t ref_mem [MEM_BYTES];
    int seed = 1274;
    int errors;
    int bursts;
    int bytes;
    string test_name;

    // Burst as the host accepted it, plus progress within it
    logic started;
    logic acc_write;
    addr_t acc_addr;
    len_t acc_len;
    int beat_cnt;
    int lat_cnt;
    int exp_lat;
    mem_idx_t exp_idx;
    byte_t exp_rd;

    psram_subsystem dut0 (
        .sck      (sck),
        .reset    (reset),
        .start    (start),
        .write    (write),
        .addr     (addr),
        .len      (len),
        .wr_data  (wr_data),
        .busy     (busy),
        .done     (done),
        .wr_take  (wr_take),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    always #20 sck = ~sck;

    // The model keeps only the low address bits, so byte offsets wrap there
    function automatic mem_idx_t mem_index(input addr_t base, input int offset);
        return mem_idx_t'(base + addr_t'(offset));
    endfunction

    // Chip-select low time of a burst
    function automatic int burst_cycles(input logic wr, input len_t n);
        if (wr) begin
            return `PSRAM_ADDR_END + 2 * int'(n);
        end
        return `PSRAM_READ_START + 2 * int'(n);
    endfunction

    function automatic len_t random_len();
        return len_t'(1 + ($unsigned($random(seed)) % 24));
    endfunction

    assign exp_idx = mem_index(acc_addr, beat_cnt);
    assign exp_lat = burst_cycles(acc_write, acc_len) + 1;
    always_comb exp_rd = ref_mem[exp_idx];

    always_ff @(posedge sck or posedge reset) begin
        if (reset) begin
            started <= 1'b0;
            acc_write <= 1'b0;
            acc_addr <= '0;
            acc_len <= '0;
            beat_cnt <= 0;
            lat_cnt <= 0;
        end else if (start && !busy) begin
            started <= 1'b1;
            acc_write <= write;
            acc_addr <= addr;
            acc_len <= len;
            beat_cnt <= 0;
            lat_cnt <= 1;
        end else begin
            lat_cnt <= lat_cnt + 1;
            if (wr_take || rd_valid) begin
                beat_cnt <= beat_cnt + 1;
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge sck) disable iff (reset)
        !started |-> !(busy || done || wr_take || rd_valid))
        else begin
            errors++;
            $display("Error %s idle: expected %b, actual %b", test_name, 4'b0000,
                     $sampled({busy, done, wr_take, rd_valid}));
        end

    a_read_data: assert property (@(posedge sck) disable iff (reset)
        rd_valid |-> rd_data == exp_rd)
        else begin
            errors++;
            $display("Error %s rd_data: expected %h, actual %h", test_name,
                     $sampled(exp_rd), $sampled(rd_data));
        end

    a_take_on_write: assert property (@(posedge sck) disable iff (reset)
        wr_take |-> acc_write)
        else begin
            errors++;
            $display("Error %s wr_take in read: expected %b, actual %b", test_name, 1'b0, 1'b1);
        end

    a_valid_on_read: assert property (@(posedge sck) disable iff (reset)
        rd_valid |-> !acc_write)
        else begin
            errors++;
            $display("Error %s rd_valid in write: expected %b, actual %b", test_name, 1'b0, 1'b1);
        end

    a_beat_count: assert property (@(posedge sck) disable iff (reset)
        done |=> beat_cnt == int'(acc_len))
        else begin
            errors++;
            $display("Error %s byte count: expected %0d, actual %0d", test_name,
                     $sampled(acc_len), $sampled(beat_cnt));
        end

    a_latency: assert property (@(posedge sck) disable iff (reset)
        done |-> lat_cnt == exp_lat)
        else begin
            errors++;
            $display("Error %s latency: expected %0d, actual %0d", test_name,
                     $sampled(exp_lat), $sampled(lat_cnt));
        end

    a_done_single: assert property (@(posedge sck) disable iff (reset)
        done |=> !done)
        else begin
            errors++;
            $display("Error %s done width: expected %b, actual %b", test_name, 1'b0, 1'b1);
        end

    a_start_accepted: assert property (@(posedge sck) disable iff (reset)
        start && !busy |=> busy)
        else begin
            errors++;
            $display("Error %s accept: expected %b, actual %b", test_name, 1'b1, 1'b0);
        end

    task automatic end_run();
        $display("Bursts %0d, bytes %0d, errors %0d", bursts, bytes, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Called in an idle cycle and returns in the idle cycle right after done
    task automatic run_burst(input logic wr, input addr_t a, input len_t n);
        byte_t data [$];
        int i;
        int k;
        int waited;
        logic took;
        data.delete();
        if (wr) begin
            for (i = 0; i < int'(n); i++) begin
                data.push_back(byte_t'($random(seed)));
                ref_mem[mem_index(a, i)] = data[i];
            end
        end
        write = wr;
        addr = a;
        len = n;
        wr_data = wr ? data[0] : byte_t'($random(seed));
        start = 1'b1;
        bursts++;
        bytes += int'(n);
        @(posedge sck);
        #DLY;
        start = 1'b0;
        // Request fields only matter at start
        write = logic'($random(seed));
        addr = addr_t'($random(seed));
        len = len_t'($random(seed));
        k = 0;
        waited = 0;
        while (!done && waited < TIMEOUT) begin
            took = wr_take;
            @(posedge sck);
            #DLY;
            waited++;
            if (took && wr) begin
                k++;
                if (k < int'(n)) begin
                    wr_data = data[k];
                end
            end
        end
        if (!done) begin
            $display("Timeout: done never came for the burst at address %h", a);
            errors++;
            end_run();
        end
        @(posedge sck);
        #DLY;
    endtask

    initial begin
        addr_t a;
        len_t n;
        len_t m;
        int i;
        sck = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        write = 1'b0;
        addr = '0;
        len = '0;
        wr_data = '0;
        errors = 0;
        bursts = 0;
        bytes = 0;
        test_name = "idle_after_reset";
        repeat (10) @(posedge sck);
        #DLY;
        reset = 1'b0;
        repeat (8) @(posedge sck);
        #DLY;

        test_name = "single_byte";
        a = addr_t'($random(seed));
        run_burst(1'b1, a, len_t'(1));
        run_burst(1'b0, a, len_t'(1));

        test_name = "random_bursts";
        for (i = 0; i < 16; i++) begin
            a = addr_t'($random(seed));
            n = random_len();
            run_burst(1'b1, a, n);
            run_burst(1'b0, a, n);
        end
        // Crosses the top of the 24-bit address space
        run_burst(1'b1, 24'hFFFFF4, len_t'(20));
        run_burst(1'b0, 24'hFFFFF4, len_t'(20));

        test_name = "adjacent_bursts";
        a = addr_t'($random(seed));
        n = random_len();
        m = random_len();
        run_burst(1'b1, a, n);
        run_burst(1'b1, a + addr_t'(n), m);
        run_burst(1'b0, a, n + m);

        test_name = "back_to_back";
        a = addr_t'($random(seed));
        n = random_len();
        run_burst(1'b1, a, n);
        run_burst(1'b0, a, n);
        run_burst(1'b0, a, n);

        end_run();
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
psram_pkg.sv
psram_model.sv
qspi_sequencer.sv
qspi_datapath.sv
psram_subsystem.sv
tb_psram_subsystem.sv
